// File: verilog/cdr_pkg.sv
`default_nettype none

package cdr_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths and pipeline constants

	// Samples in one fabric word at four samples per bit
	localparam int samples_per_word = 16;

	// Edge history spans the current word and the one before it
	localparam int edge_hist_w = 2 * samples_per_word;

	// One slicer stage per possible bit in a word
	localparam int num_slices = 5;

	// Aligner register plus one register per slicer
	localparam int pipe_latency = num_slices + 1;

	//////////////////////////////////////////////////////////////////////
	// Word types

	// Raw samples with the oldest sample in the MSB
	typedef logic [samples_per_word-1:0] sample_word_t;

	// Flag i is set when sample i and sample i+1 differ
	// Flag 15 looks back at the LSB of the previous word
	typedef logic [samples_per_word-1:0] edge_word_t;

	// Previous edge word in the high half and current in the low half
	typedef logic [edge_hist_w-1:0] edge_hist_t;

	// Index of the next sample point inside the word
	typedef logic [$clog2(samples_per_word)-1:0] phase_t;

	// Recovered bits with the newest bit shifted into the LSB
	typedef logic [num_slices-1:0] rx_data_t;

	// Number of valid bits in rx_data_t, 0 to num_slices
	typedef logic [$clog2(num_slices+1)-1:0] rx_count_t;

endpackage

`default_nettype wire

// File: verilog/cdr_phase_align.sv
`default_nettype none
`timescale 1ns/10ps

module cdr_phase_align (
	input logic clk_312p5mhz,
	input logic arst_n,
	input cdr_pkg::sample_word_t samples,
	output cdr_pkg::sample_word_t samples_aligned,
	output cdr_pkg::edge_word_t edges,
	output cdr_pkg::phase_t start
);

	//////////////////////////////////////////////////////////////////////
	// Edge detection

	// Registered edge flags of the word in the output register
	// They become the history half when the next word arrives
	cdr_pkg::edge_word_t edge_hist;

	// Edge flags of the incoming word and the history they produce
	cdr_pkg::edge_word_t edges_next;
	cdr_pkg::edge_hist_t hist_next;

	// Selected first sample point for the incoming word
	cdr_pkg::phase_t start_next;

	// Position of the first edge found by the search
	logic [4:0] first_edge;
	logic found;

	// Split-run decisions for an edge at position 12 or 13
	logic prev_quiet;
	logic hold_12;
	logic hold_13;
	logic move_12;
	logic move_13;

	// Compare each sample with the one after it in time
	// The last sample of the previous word is still held in samples_aligned
	assign edges_next[cdr_pkg::samples_per_word-1] =
		samples[cdr_pkg::samples_per_word-1] ^ samples_aligned[0];
	assign edges_next[cdr_pkg::samples_per_word-2:0] =
		samples[cdr_pkg::samples_per_word-2:0] ^ samples[cdr_pkg::samples_per_word-1:1];

	// The registered word sits in the high half behind the incoming flags
	assign hist_next = {edge_hist, edges_next};

	//////////////////////////////////////////////////////////////////////
	// Split-run corrections

	// No edge at all in the previous word
	assign prev_quiet = ~|hist_next[31:16];

	// An edge at 12 means a run of 3 samples ends in this word
	// If the previous word already sampled this run, keep start at 11 and
	// let the slicer skip it. Runs of 2+3, 6+3 and 10+3 fall in this group
	// A quiet previous word that started at 12 ended its sampling on
	// sample 0, so that run has already been taken too
	assign hold_12 = (prev_quiet && (start == 4'd12)) ||
		(~|hist_next[28:15] && hist_next[29]) ||
		(~|hist_next[20:15] && hist_next[21]) ||
		(~|hist_next[24:15] && hist_next[25]);

	// Runs of 1+3, 3+3 and 4+3 are rounded up to a bit sampled at 15
	assign move_12 = !hold_12 && (~|hist_next[17:15] || hist_next[16]);

	// An edge at 13 ends a 2-sample tail of a run from the previous word
	// Lengths that the previous word has fully consumed keep start at 12
	// A quiet previous word that started at 12 or 13 covers 2+16+2 and 3+16+2
	assign hold_13 = (prev_quiet && ((start == 4'd12) || (start == 4'd13))) ||
		(~|hist_next[30:15] && hist_next[31]) ||
		(~|hist_next[29:15] && hist_next[30]) ||
		(~|hist_next[28:15] && hist_next[29]) ||
		(~|hist_next[25:15] && hist_next[26]) ||
		(~|hist_next[24:15] && hist_next[25]) ||
		(~|hist_next[21:15] && hist_next[22]) ||
		(~|hist_next[20:15] && hist_next[21]);

	// Short tails such as 1+2 and 5+2 still need a sample at 15
	assign move_13 = !hold_13 && (~|hist_next[19:14] || hist_next[16]);

	//////////////////////////////////////////////////////////////////////
	// First sample point

	always_comb begin
		found = 1'b0;
		first_edge = '0;
		start_next = 4'd15;

		// An edge in the first four samples gives the most direct alignment
		for (int i = 15; i >= 12; i--) begin
			if (hist_next[i] && !found) begin
				found = 1'b1;
				first_edge = 5'(i);
			end
		end

		if (found) begin
			// Sample one position after the edge
			start_next = cdr_pkg::phase_t'(first_edge[3:0] - 4'd1);
			if ((first_edge == 5'd12) && move_12)
				start_next = 4'd15;
			if ((first_edge == 5'd13) && move_13)
				start_next = 4'd15;
		end else begin
			// Look back into the previous word, nearest edge first
			for (int i = 16; i <= 30; i++) begin
				if (hist_next[i] && !found) begin
					found = 1'b1;
					first_edge = 5'(i);
				end
			end

			// Then search forward through the rest of this word
			for (int i = 11; i >= 0; i--) begin
				if (hist_next[i] && !found) begin
					found = 1'b1;
					first_edge = 5'(i);
				end
			end

			// Only the phase of the edge within a bit period matters here
			// With no edge at all first_edge stays 0 and maps to 15
			case (first_edge[1:0])
				2'd0: start_next = 4'd15;
				2'd1: start_next = 4'd12;
				2'd2: start_next = 4'd13;
				default: start_next = 4'd14;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Output register

	always_ff @(posedge clk_312p5mhz or negedge arst_n) begin
		if (!arst_n) begin
			samples_aligned <= '0;
			edge_hist <= '0;
			start <= '0;
		end else begin
			samples_aligned <= samples;
			edge_hist <= edges_next;
			start <= start_next;
		end
	end

	// Slicers walk the word with the edges found in it
	assign edges = edge_hist;

endmodule

`default_nettype wire

// File: verilog/cdr_bit_slice.sv
`default_nettype none
`timescale 1ns/10ps

module cdr_bit_slice (
	input logic clk_312p5mhz,
	input logic arst_n,
	input cdr_pkg::sample_word_t samples_in,
	input cdr_pkg::edge_word_t edges_in,
	input cdr_pkg::phase_t start_in,
	input cdr_pkg::rx_data_t data_in,
	input cdr_pkg::rx_count_t count_in,
	input logic done_in,
	output cdr_pkg::sample_word_t samples_out,
	output cdr_pkg::edge_word_t edges_out,
	output cdr_pkg::phase_t start_out,
	output cdr_pkg::rx_data_t data_out,
	output cdr_pkg::rx_count_t count_out,
	output logic done_out
);

	// Edge flag d positions below phase p
	// Positions below 0 belong to the next word and read as no edge
	function automatic logic edge_below(cdr_pkg::edge_word_t e, cdr_pkg::phase_t p, int d);
		logic [4:0] pos;
		pos = {1'b0, p} - 5'(d);
		return !pos[4] && e[pos[3:0]];
	endfunction

	cdr_pkg::phase_t start_comb;
	cdr_pkg::phase_t step;
	cdr_pkg::rx_data_t data_comb;
	cdr_pkg::rx_count_t count_comb;
	logic done_comb;

	always_comb begin
		start_comb = start_in;
		data_comb = data_in;
		count_comb = count_in;
		done_comb = done_in;
		step = 4'd4;

		if (done_in) begin
			// The word is used up so the stage only forwards
		end else if ((count_in == '0) && edge_below(edges_in, start_in, 1)) begin
			// The first point sits right on an edge already sampled last word
		end else begin
			count_comb = cdr_pkg::rx_count_t'(count_in + 1'b1);
			data_comb = {data_in[cdr_pkg::num_slices-2:0], samples_in[start_in]};

			// The next edge should come 3 to 5 samples on
			// Re-center one sample past it, or assume a nominal bit if none
			if (edge_below(edges_in, start_in, 2))
				step = 4'd3;
			else if (edge_below(edges_in, start_in, 3))
				step = 4'd4;
			else if (edge_below(edges_in, start_in, 4))
				step = 4'd5;
			else
				step = 4'd4;

			start_comb = start_in - step;
			done_comb = (start_in < step);
		end
	end

	always_ff @(posedge clk_312p5mhz or negedge arst_n) begin
		if (!arst_n) begin
			samples_out <= '0;
			edges_out <= '0;
			start_out <= '0;
			data_out <= '0;
			count_out <= '0;
			done_out <= 1'b0;
		end else begin
			samples_out <= samples_in;
			edges_out <= edges_in;
			start_out <= start_comb;
			data_out <= data_comb;
			count_out <= count_comb;
			done_out <= done_comb;
		end
	end

endmodule

`default_nettype wire

// File: verilog/cdr_top.sv
`default_nettype none
`timescale 1ns/10ps

module cdr_top (
	input logic clk_312p5mhz,
	input logic arst_n,
	input cdr_pkg::sample_word_t samples,
	output cdr_pkg::rx_data_t rx_data,
	output cdr_pkg::rx_count_t rx_data_count
);

	//////////////////////////////////////////////////////////////////////
	// Slicer chain links

	// Link k feeds slicer k and link num_slices is the chain output
	cdr_pkg::sample_word_t chain_samples [cdr_pkg::num_slices+1];
	cdr_pkg::edge_word_t chain_edges [cdr_pkg::num_slices+1];
	cdr_pkg::phase_t chain_start [cdr_pkg::num_slices+1];
	cdr_pkg::rx_data_t chain_data [cdr_pkg::num_slices+1];
	cdr_pkg::rx_count_t chain_count [cdr_pkg::num_slices+1];
	logic chain_done [cdr_pkg::num_slices+1];

	//////////////////////////////////////////////////////////////////////
	// Edge finding and first phase

	cdr_phase_align u_phase_align (
		.clk_312p5mhz(clk_312p5mhz),
		.arst_n(arst_n),
		.samples(samples),
		.samples_aligned(chain_samples[0]),
		.edges(chain_edges[0]),
		.start(chain_start[0])
	);

	// Every word enters the chain with no bits taken
	assign chain_data[0] = '0;
	assign chain_count[0] = '0;
	assign chain_done[0] = 1'b0;

	//////////////////////////////////////////////////////////////////////
	// Bit slicers

	// Stage k takes bit k+1 of the word when there is one
	for (genvar k = 0; k < cdr_pkg::num_slices; k++) begin : g_slice
		cdr_bit_slice u_bit_slice (
			.clk_312p5mhz(clk_312p5mhz),
			.arst_n(arst_n),
			.samples_in(chain_samples[k]),
			.edges_in(chain_edges[k]),
			.start_in(chain_start[k]),
			.data_in(chain_data[k]),
			.count_in(chain_count[k]),
			.done_in(chain_done[k]),
			.samples_out(chain_samples[k+1]),
			.edges_out(chain_edges[k+1]),
			.start_out(chain_start[k+1]),
			.data_out(chain_data[k+1]),
			.count_out(chain_count[k+1]),
			.done_out(chain_done[k+1])
		);
	end

	// The last stage holds the finished word
	assign rx_data = chain_data[cdr_pkg::num_slices];
	assign rx_data_count = chain_count[cdr_pkg::num_slices];

endmodule

`default_nettype wire

// File: testbench/cdr_props.sv
`default_nettype none
`timescale 1ns/10ps

module cdr_props (
	input logic clk_312p5mhz,
	input logic arst_n,
	input cdr_pkg::rx_count_t count_in,
	input cdr_pkg::rx_count_t count_out,
	input logic done_in
);

	//////////////////////////////////////////////////////////////////////
	// Count range

	// A word never yields more bits than there are slicer stages
	count_in_range: assert property (
		@(posedge clk_312p5mhz) disable iff (!arst_n)
		count_out <= cdr_pkg::rx_count_t'(cdr_pkg::num_slices)
	) else $error("bit count above the number of slicer stages");

	//////////////////////////////////////////////////////////////////////
	// Finished words

	// Once a word is used up, later stages only forward it
	// The count one cycle later must be the count seen with done set
	count_held_when_done: assert property (
		@(posedge clk_312p5mhz) disable iff (!arst_n)
		done_in |=> (count_out == $past(count_in))
	) else $error("slicer changed the count of a finished word");

endmodule

`default_nettype wire

// File: testbench/cdr_tb.sv
`default_nettype none
`timescale 1ns/10ps

module cdr_tb;

	logic clk_312p5mhz;
	logic arst_n;
	cdr_pkg::sample_word_t samples;
	cdr_pkg::rx_data_t rx_data;
	cdr_pkg::rx_count_t rx_data_count;

	// Sample stream in time order and the words cut from it
	logic sample_q[$];
	cdr_pkg::sample_word_t words[$];

	// Predicted output for each word
	cdr_pkg::rx_data_t exp_data[$];
	cdr_pkg::rx_count_t exp_count[$];

	int seed = 32'h5803;
	int error_count = 0;
	bit stream_ready = 0;
	bit compare_done = 0;

	cdr_top u_dut (
		.clk_312p5mhz(clk_312p5mhz),
		.arst_n(arst_n),
		.samples(samples),
		.rx_data(rx_data),
		.rx_data_count(rx_data_count)
	);

	// Properties on the output and on every slicer stage
	// At the top the last link of the chain feeds the output count
	bind cdr_top cdr_props u_top_props (
		.clk_312p5mhz(clk_312p5mhz),
		.arst_n(arst_n),
		.count_in(chain_count[cdr_pkg::num_slices-1]),
		.count_out(rx_data_count),
		.done_in(chain_done[cdr_pkg::num_slices-1])
	);

	bind cdr_bit_slice cdr_props u_slice_props (
		.clk_312p5mhz(clk_312p5mhz),
		.arst_n(arst_n),
		.count_in(count_in),
		.count_out(count_out),
		.done_in(done_in)
	);

	initial begin
		clk_312p5mhz = 1'b0;
		forever #100 clk_312p5mhz = ~clk_312p5mhz;
	end

	//////////////////////////////////////////////////////////////////////
	// Error handling

	task automatic stop_on_error(input string what);
		error_count++;
		$display("%s", what);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_rx_data(input cdr_pkg::rx_data_t expected,
		input cdr_pkg::rx_data_t actual);
		if (actual !== expected)
			stop_on_error($sformatf("[FAIL] %0t rx_data expected %b got %b",
				$time, expected, actual));
	endtask

	task automatic check_rx_count(input cdr_pkg::rx_count_t expected,
		input cdr_pkg::rx_count_t actual);
		if (actual !== expected)
			stop_on_error($sformatf("[FAIL] %0t rx_data_count expected %0d got %0d",
				$time, expected, actual));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference model

	// True when no edge flag is set from lo up to hi
	function automatic bit quiet(input logic [31:0] h, input int lo, input int hi);
		for (int i = lo; i <= hi; i++)
			if (h[i])
				return 0;
		return 1;
	endfunction

	// An edge at k that is the first one above position 15
	function automatic bit lone(input logic [31:0] h, input int k);
		return h[k] && quiet(h, 15, k - 1);
	endfunction

	// First sample point of a word from its edges, the previous edges and start
	function automatic int align_ref(input logic [15:0] cur, input logic [15:0] prev,
		input int prev_start);
		logic [31:0] h;
		int pos;
		bit hold12;
		bit hold13;
		h = {prev, cur};
		hold12 = (quiet(h, 16, 31) && prev_start == 12) ||
			lone(h, 29) || lone(h, 25) || lone(h, 21);
		hold13 = (quiet(h, 16, 31) && (prev_start == 12 || prev_start == 13)) ||
			lone(h, 31) || lone(h, 30) || lone(h, 29) || lone(h, 26) ||
			lone(h, 25) || lone(h, 22) || lone(h, 21);
		for (int k = 15; k >= 12; k--) begin
			if (h[k]) begin
				if (k == 12 && !hold12 && (quiet(h, 15, 17) || h[16]))
					return 15;
				if (k == 13 && !hold13 && (quiet(h, 14, 19) || h[16]))
					return 15;
				return k - 1;
			end
		end
		pos = 0;
		for (int k = 16; k <= 30 && pos == 0; k++)
			if (h[k])
				pos = k;
		for (int k = 11; k >= 0 && pos == 0; k--)
			if (h[k])
				pos = k;
		// An edge at position 0 and no edge at all both land on 15
		case (pos % 4)
			0: return 15;
			1: return 12;
			2: return 13;
			default: return 14;
		endcase
	endfunction

	// Edge at a position inside the word, anything below 0 reads as none
	function automatic bit edge_at(input logic [15:0] e, input int pos);
		return pos >= 0 && e[pos];
	endfunction

	// Walk the word with five slicers and return count and data
	function automatic logic [7:0] slice_ref(input logic [15:0] s, input logic [15:0] e,
		input int start);
		int p;
		int step;
		int cnt;
		logic [4:0] data;
		bit done;
		p = start;
		cnt = 0;
		data = '0;
		done = 0;
		for (int k = 0; k < cdr_pkg::num_slices; k++) begin
			if (done || (cnt == 0 && edge_at(e, p - 1)))
				continue;
			data = {data[3:0], s[p]};
			cnt++;
			if (edge_at(e, p - 2))
				step = 3;
			else if (edge_at(e, p - 4) && !edge_at(e, p - 3))
				step = 5;
			else
				step = 4;
			done = p < step;
			p = (p - step) & 15;
		end
		return {cnt[2:0], data};
	endfunction

	// Predict every word, starting from the reset state of the aligner
	task automatic predict_all();
		logic prev_lsb;
		logic [15:0] prev_edges;
		logic [15:0] e;
		logic [7:0] r;
		int prev_start;
		int st;
		prev_lsb = 1'b0;
		prev_edges = '0;
		prev_start = 0;
		foreach (words[n]) begin
			e[15] = words[n][15] ^ prev_lsb;
			for (int i = 0; i < 15; i++)
				e[i] = words[n][i] ^ words[n][i+1];
			st = align_ref(e, prev_edges, prev_start);
			r = slice_ref(words[n], e, st);
			exp_data.push_back(r[4:0]);
			exp_count.push_back(r[7:5]);
			prev_lsb = words[n][0];
			prev_edges = e;
			prev_start = st;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus streams

	task automatic add_run(input logic value, input int len);
		repeat (len) sample_q.push_back(value);
	endtask

	function automatic int pick(input int range);
		return int'($unsigned($random(seed)) % range);
	endfunction

	task automatic build_stream();
		logic bit_val;
		cdr_pkg::sample_word_t w;
		// Constant levels
		add_run(1'b0, 8 * 16);
		add_run(1'b1, 8 * 16);
		// Nominal four-sample bits at each phase offset
		for (int off = 0; off < 4; off++) begin
			add_run(1'b0, off + 1);
			repeat (48) add_run(pick(2) != 0, 4);
		end
		// Bits stretched or shrunk by one sample
		repeat (160) add_run(pick(2) != 0, 3 + pick(3));
		// Long runs of alternating level that cross word boundaries
		bit_val = 1'b0;
		repeat (24) begin
			add_run(bit_val, 4 * (1 + pick(22)));
			bit_val = ~bit_val;
		end
		// Mixed short and long runs for the split cases
		repeat (60) begin
			add_run(bit_val, pick(2) != 0 ? 2 + pick(4) : 16 + pick(8));
			bit_val = ~bit_val;
		end
		while (sample_q.size() % 16 != 0)
			sample_q.push_back(bit_val);
		// The first sample in time goes into the MSB
		while (sample_q.size() > 0) begin
			for (int i = 15; i >= 0; i--)
				w[i] = sample_q.pop_front();
			words.push_back(w);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		samples = '0;
		arst_n = 1'b0;
		build_stream();
		predict_all();
		stream_ready = 1;
		repeat (3) begin
			@(negedge clk_312p5mhz);
			check_rx_count('0, rx_data_count);
		end
		arst_n = 1'b1;
		foreach (words[n]) begin
			samples = words[n];
			@(negedge clk_312p5mhz);
		end
		samples = '0;
		wait (compare_done);
		if (error_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// Word n is driven at the n-th falling edge after reset and read 6 later
	initial begin
		int cyc;
		int idx;
		cyc = 0;
		wait (arst_n === 1'b1);
		while (cyc < words.size() + cdr_pkg::pipe_latency - 1) begin
			@(negedge clk_312p5mhz);
			cyc++;
			idx = cyc - cdr_pkg::pipe_latency;
			if (idx >= 0) begin
				check_rx_count(exp_count[idx], rx_data_count);
				check_rx_data(exp_data[idx], rx_data);
				// The first eight words are all zero and the next eight all one
				// Each of them holds four whole bits
				if (idx < 16) begin
					check_rx_count(cdr_pkg::rx_count_t'(4), rx_data_count);
					check_rx_data(idx < 8 ? cdr_pkg::rx_data_t'(0) :
						cdr_pkg::rx_data_t'(4'hF), rx_data);
				end
			end
		end
		compare_done = 1;
	end

	// Watchdog sized from the word count plus reset and a margin
	initial begin
		wait (stream_ready);
		#((words.size() + cdr_pkg::pipe_latency + 40) * 200);
		stop_on_error("watchdog expired before all words were checked");
	end

endmodule

`default_nettype wire

// File: flist.f
verilog/cdr_pkg.sv
verilog/cdr_phase_align.sv
verilog/cdr_bit_slice.sv
verilog/cdr_top.sv
testbench/cdr_props.sv
testbench/cdr_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the CDR testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module cdr_tb \
	-f flist.f \
	-o cdr_sim

# The simulator exits non-zero on a failure, the grep decides the result
out=$(./obj_dir/cdr_sim || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
	exit 0
else
	exit 1
fi
